// File: design/core_isa_pkg.sv
package core_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // Instruction field positions.
  localparam int opcode_w   = 7;
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;

  typedef enum logic [opcode_w-1:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  // Low three bits follow funct3, top bit is funct7[5].
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_sra    = 4'b1101,
    alu_pass_b = 4'b1111
  } alu_op_e;

  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_op_e;

  typedef enum logic [1:0] {a_rs1, a_pc} a_sel_e;
  typedef enum logic [1:0] {b_rs2, b_imm} b_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_load, wb_link} wb_sel_e;

endpackage

// File: design/core_bus_pkg.sv
package core_bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int be_w   = 4;

  // First fetch address.
  localparam logic [addr_w-1:0] reset_pc = '0;

  // Access size, encoded as the load and store funct3.
  typedef enum logic [2:0] {
    size_byte   = 3'b000,
    size_half   = 3'b001,
    size_word   = 3'b010,
    size_byte_u = 3'b100,
    size_half_u = 3'b101
  } mem_size_e;

endpackage

// File: design/core_exec_if.sv
interface core_exec_if
  import core_isa_pkg::*, core_bus_pkg::*;
();

  alu_op_e                 alu_op;
  a_sel_e                  a_sel;
  b_sel_e                  b_sel;
  logic [xlen-1:0]         imm;
  logic [reg_addr_w-1:0]   rs1;
  logic [reg_addr_w-1:0]   rs2;
  logic [reg_addr_w-1:0]   rd;
  logic                    reg_write;
  logic                    is_branch;
  logic                    is_jal;
  logic                    is_jalr;
  br_op_e                  br_op;
  logic                    mem_read;
  logic                    mem_write;
  mem_size_e               mem_size;

  modport dec (
    output alu_op, a_sel, b_sel, imm, rs1, rs2, rd, reg_write,
           is_branch, is_jal, is_jalr, br_op, mem_read, mem_write, mem_size
  );
  modport ctrl (input rd, reg_write, is_branch, is_jal, is_jalr, mem_read, mem_write);
  modport alu (input alu_op, a_sel, b_sel, imm, br_op, is_branch, is_jal, is_jalr);
  modport lsu (input mem_read, mem_write, mem_size);

endinterface

// File: design/core_ctrl.sv
module core_ctrl
  import core_isa_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  core_exec_if.ctrl    ex,
  input  logic         fetch_done,
  input  logic         mem_done,
  output logic         fetch_start,
  output logic         mem_start,
  output logic         rf_we,
  output logic         pc_update,
  output wb_sel_e      wb_sel
);

  typedef enum logic [2:0] {
    s_idle,
    s_fetch,
    s_decode,
    s_execute,
    s_mem,
    s_writeback
  } ctrl_state_e;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        is_mem;

  assign is_mem = ex.mem_read | ex.mem_write;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // Strobes go out one cycle ahead of the bus phase they start.
  always_comb begin
    state_next  = state;
    fetch_start = 1'b0;
    mem_start   = 1'b0;
    rf_we       = 1'b0;
    pc_update   = 1'b0;
    case (state)
      s_idle: begin
        fetch_start = 1'b1;
        state_next  = s_fetch;
      end
      s_fetch: begin
        if (fetch_done) begin
          state_next = s_decode;
        end
      end
      s_decode: state_next = s_execute;
      s_execute: begin
        if (is_mem) begin
          mem_start  = 1'b1;
          state_next = s_mem;
        end else begin
          state_next = s_writeback;
        end
      end
      s_mem: begin
        if (mem_done) begin
          state_next = s_writeback;
        end
      end
      s_writeback: begin
        rf_we       = ex.reg_write && (ex.rd != '0);
        pc_update   = 1'b1;
        fetch_start = 1'b1;
        state_next  = s_fetch;
      end
      default: state_next = s_idle;
    endcase
  end

  always_comb begin
    if (ex.is_jal || ex.is_jalr) begin
      wb_sel = wb_link;
    end else if (ex.mem_read) begin
      wb_sel = wb_load;
    end else begin
      wb_sel = wb_alu;
    end
  end

endmodule

// File: design/core_ifu.sv
module core_ifu
  import core_bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  input  logic              fetch_start,
  input  logic              pc_update,
  input  logic              take_branch,
  input  logic [addr_w-1:0] target,
  output logic [addr_w-1:0] pc,
  output logic [data_w-1:0] instr,
  output logic              fetch_done,
  output logic [addr_w-1:0] istr_address,
  output logic              istr_read,
  input  logic [data_w-1:0] istr_readdata,
  input  logic              istr_waitrequest
);

  assign istr_address = pc;
  assign fetch_done   = istr_read & ~istr_waitrequest;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= reset_pc;
      istr_read <= 1'b0;
    end else begin
      if (pc_update) begin
        pc <= take_branch ? target : pc + addr_w'(4);
      end
      // Read stays up until the bus accepts it.
      if (fetch_start) begin
        istr_read <= 1'b1;
      end else if (fetch_done) begin
        istr_read <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      instr <= istr_readdata;
    end
  end

endmodule

// File: design/core_decoder.sv
module core_decoder
  import core_isa_pkg::*, core_bus_pkg::*;
(
  input  logic [data_w-1:0] instr,
  core_exec_if.dec          ex
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic            sub_bit;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  assign opcode = opcode_e'(instr[opcode_w-1:0]);
  assign funct3 = instr[funct3_lsb +: 3];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Only SUB and SRA/SRAI use funct7[5].
  assign sub_bit = instr[funct7_lsb + 5] &&
                   ((funct3 == 3'b101) || (opcode == opc_op && funct3 == 3'b000));

  assign ex.rs1      = instr[rs1_lsb +: reg_addr_w];
  assign ex.rs2      = instr[rs2_lsb +: reg_addr_w];
  assign ex.rd       = instr[rd_lsb +: reg_addr_w];
  assign ex.br_op    = br_op_e'(funct3);
  assign ex.mem_size = mem_size_e'(funct3);

  always_comb begin
    ex.alu_op    = alu_add;
    ex.a_sel     = a_rs1;
    ex.b_sel     = b_imm;
    ex.imm       = imm_i;
    ex.reg_write = 1'b0;
    ex.is_branch = 1'b0;
    ex.is_jal    = 1'b0;
    ex.is_jalr   = 1'b0;
    ex.mem_read  = 1'b0;
    ex.mem_write = 1'b0;
    case (opcode)
      opc_lui: begin
        ex.alu_op    = alu_pass_b;
        ex.imm       = imm_u;
        ex.reg_write = 1'b1;
      end
      opc_auipc: begin
        ex.a_sel     = a_pc;
        ex.imm       = imm_u;
        ex.reg_write = 1'b1;
      end
      opc_jal: begin
        ex.a_sel     = a_pc;
        ex.imm       = imm_j;
        ex.reg_write = 1'b1;
        ex.is_jal    = 1'b1;
      end
      opc_jalr: begin
        ex.reg_write = 1'b1;
        ex.is_jalr   = 1'b1;
      end
      // ALU forms the target, the compare runs beside it.
      opc_branch: begin
        ex.a_sel     = a_pc;
        ex.imm       = imm_b;
        ex.is_branch = 1'b1;
      end
      opc_load: begin
        ex.reg_write = 1'b1;
        ex.mem_read  = 1'b1;
      end
      opc_store: begin
        ex.imm       = imm_s;
        ex.mem_write = 1'b1;
      end
      opc_op_imm: begin
        ex.alu_op    = alu_op_e'({sub_bit, funct3});
        ex.reg_write = 1'b1;
      end
      opc_op: begin
        ex.alu_op    = alu_op_e'({sub_bit, funct3});
        ex.b_sel     = b_rs2;
        ex.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: design/core_regfile.sv
module core_regfile
  import core_isa_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic                  we,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       wdata
);

  // No storage behind x0.
  logic [xlen-1:0] regs [1:num_regs-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

endmodule

// File: design/core_alu.sv
module core_alu
  import core_isa_pkg::*, core_bus_pkg::*;
(
  core_exec_if.alu          ex,
  input  logic [addr_w-1:0] pc,
  input  logic [xlen-1:0]   rs1_data,
  input  logic [xlen-1:0]   rs2_data,
  output logic [xlen-1:0]   result,
  output logic              take_branch
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            cond;

  assign op_a  = (ex.a_sel == a_pc) ? pc : rs1_data;
  assign op_b  = (ex.b_sel == b_imm) ? ex.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ex.alu_op)
      alu_sub:    result = op_a - op_b;
      alu_sll:    result = op_a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    result = op_a ^ op_b;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $signed(op_a) >>> shamt;
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_pass_b: result = op_b;
      default:    result = op_a + op_b;
    endcase
    // JALR target has bit 0 cleared.
    if (ex.is_jalr) begin
      result[0] = 1'b0;
    end
  end

  always_comb begin
    case (ex.br_op)
      br_eq:   cond = rs1_data == rs2_data;
      br_ne:   cond = rs1_data != rs2_data;
      br_lt:   cond = $signed(rs1_data) < $signed(rs2_data);
      br_ge:   cond = $signed(rs1_data) >= $signed(rs2_data);
      br_ltu:  cond = rs1_data < rs2_data;
      br_geu:  cond = rs1_data >= rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = ex.is_jal | ex.is_jalr | (ex.is_branch & cond);

endmodule

// File: design/core_lsu.sv
module core_lsu
  import core_bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  core_exec_if.lsu          ex,
  input  logic              mem_start,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] store_data,
  output logic [data_w-1:0] load_data,
  output logic              mem_done,
  output logic [addr_w-1:0] data_address,
  output logic              data_read,
  output logic              data_write,
  output logic [data_w-1:0] data_writedata,
  output logic [be_w-1:0]   data_byteenable,
  input  logic [data_w-1:0] data_readdata,
  input  logic              data_waitrequest
);

  logic [1:0]        offset;
  logic [1:0]        offset_q;
  logic [data_w-1:0] lanes;
  logic [be_w-1:0]   be;
  logic [data_w-1:0] rd_shift;
  logic [data_w-1:0] rd_ext;

  assign mem_done = (data_read | data_write) & ~data_waitrequest;

  // Misaligned halfwords and words fall back to the aligned lanes.
  always_comb begin
    case (ex.mem_size)
      size_byte, size_byte_u: begin
        offset = addr[1:0];
        lanes  = {4{store_data[7:0]}};
        be     = 4'b0001 << offset;
      end
      size_half, size_half_u: begin
        offset = {addr[1], 1'b0};
        lanes  = {2{store_data[15:0]}};
        be     = 4'b0011 << offset;
      end
      default: begin
        offset = 2'b00;
        lanes  = store_data;
        be     = 4'b1111;
      end
    endcase
  end

  assign rd_shift = data_readdata >> {offset_q, 3'b000};

  always_comb begin
    case (ex.mem_size)
      size_byte:   rd_ext = {{24{rd_shift[7]}}, rd_shift[7:0]};
      size_byte_u: rd_ext = {24'b0, rd_shift[7:0]};
      size_half:   rd_ext = {{16{rd_shift[15]}}, rd_shift[15:0]};
      size_half_u: rd_ext = {16'b0, rd_shift[15:0]};
      default:     rd_ext = rd_shift;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_read  <= 1'b0;
      data_write <= 1'b0;
    end else if (mem_start) begin
      data_read  <= ex.mem_read;
      data_write <= ex.mem_write;
    end else if (mem_done) begin
      data_read  <= 1'b0;
      data_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      data_address    <= {addr[addr_w-1:2], 2'b00};
      data_writedata  <= lanes;
      data_byteenable <= ex.mem_read ? 4'b1111 : be;
      offset_q        <= offset;
    end
    if (mem_done && data_read) begin
      load_data <= rd_ext;
    end
  end

endmodule

// File: design/core_top.sv
module core_top
  import core_isa_pkg::*, core_bus_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n,
  output logic [addr_w-1:0] istr_address,
  output logic              istr_read,
  input  logic [data_w-1:0] istr_readdata,
  input  logic              istr_waitrequest,
  output logic [addr_w-1:0] data_address,
  output logic              data_read,
  output logic              data_write,
  output logic [data_w-1:0] data_writedata,
  output logic [be_w-1:0]   data_byteenable,
  input  logic [data_w-1:0] data_readdata,
  input  logic              data_waitrequest
);

  logic              ctl_fetch_start;
  logic              ctl_fetch_done;
  logic              ctl_mem_start;
  logic              ctl_mem_done;
  logic              ctl_pc_update;
  wb_sel_e           ctl_wb_sel;

  logic [addr_w-1:0] if_pc;
  logic [data_w-1:0] if_instr;

  logic [xlen-1:0]   ex_rs1_data;
  logic [xlen-1:0]   ex_rs2_data;
  logic [xlen-1:0]   ex_result;
  logic              ex_take_branch;

  logic [data_w-1:0] mem_load_data;

  logic              wb_we;
  logic [xlen-1:0]   wb_data;

  core_exec_if ex ();

  core_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .ex          (ex.ctrl),
    .fetch_done  (ctl_fetch_done),
    .mem_done    (ctl_mem_done),
    .fetch_start (ctl_fetch_start),
    .mem_start   (ctl_mem_start),
    .rf_we       (wb_we),
    .pc_update   (ctl_pc_update),
    .wb_sel      (ctl_wb_sel)
  );

  core_ifu u_ifu (
    .clk              (clk),
    .arst_n           (arst_n),
    .fetch_start      (ctl_fetch_start),
    .pc_update        (ctl_pc_update),
    .take_branch      (ex_take_branch),
    .target           (ex_result),
    .pc               (if_pc),
    .instr            (if_instr),
    .fetch_done       (ctl_fetch_done),
    .istr_address     (istr_address),
    .istr_read        (istr_read),
    .istr_readdata    (istr_readdata),
    .istr_waitrequest (istr_waitrequest)
  );

  core_decoder u_decoder (
    .instr (if_instr),
    .ex    (ex.dec)
  );

  core_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (ex.rs1),
    .rs2      (ex.rs2),
    .rs1_data (ex_rs1_data),
    .rs2_data (ex_rs2_data),
    .we       (wb_we),
    .rd       (ex.rd),
    .wdata    (wb_data)
  );

  core_alu u_alu (
    .ex          (ex.alu),
    .pc          (if_pc),
    .rs1_data    (ex_rs1_data),
    .rs2_data    (ex_rs2_data),
    .result      (ex_result),
    .take_branch (ex_take_branch)
  );

  core_lsu u_lsu (
    .clk              (clk),
    .arst_n           (arst_n),
    .ex               (ex.lsu),
    .mem_start        (ctl_mem_start),
    .addr             (ex_result),
    .store_data       (ex_rs2_data),
    .load_data        (mem_load_data),
    .mem_done         (ctl_mem_done),
    .data_address     (data_address),
    .data_read        (data_read),
    .data_write       (data_write),
    .data_writedata   (data_writedata),
    .data_byteenable  (data_byteenable),
    .data_readdata    (data_readdata),
    .data_waitrequest (data_waitrequest)
  );

  // Link value is the pc of the jump plus four.
  always_comb begin
    case (ctl_wb_sel)
      wb_load: wb_data = mem_load_data;
      wb_link: wb_data = if_pc + addr_w'(4);
      default: wb_data = ex_result;
    endcase
  end

endmodule

// File: tb/core_tb.sv
module core_tb
  import core_bus_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] op_r = 7'h33;
  localparam logic [6:0] op_i = 7'h13;
  localparam logic [6:0] op_ld = 7'h03;
  localparam int data_base = 32'h200;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
    logic [be_w-1:0]   be;
  } store_t;

  logic              clk;
  logic              arst_n;
  logic [addr_w-1:0] istr_address;
  logic              istr_read;
  logic [data_w-1:0] istr_readdata;
  logic              istr_waitrequest;
  logic [addr_w-1:0] data_address;
  logic              data_read;
  logic              data_write;
  logic [data_w-1:0] data_writedata;
  logic [be_w-1:0]   data_byteenable;
  logic [data_w-1:0] data_readdata;
  logic              data_waitrequest;

  logic [31:0] mem [0:255];
  store_t      exp_q[$];
  store_t      head;
  logic [31:0] mask;
  logic [31:0] prev_fetch;
  logic [6:0]  prev_op;
  logic        have_prev;
  logic        seen_fetch;
  int          pc;
  int          st_off;
  int          iwait;
  int          dwait;
  int          cycles;
  int          limit;
  int          store_errors;
  int          bus_errors;
  int          other_errors;

  core_top dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_r};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic emit(logic [31:0] word);
    mem[pc / 4] = word;
    pc += 4;
  endtask

  task automatic expect_store(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
    exp_q.push_back('{addr, data, be});
  endtask

  // SW of a register into the next result slot.
  task automatic store_result(int rs, logic [31:0] value);
    emit(enc_s(st_off, rs, 1, 2));
    expect_store(data_base + st_off, value, 4'hf);
    st_off += 4;
  endtask

  task automatic branch_case(int f3, int rs1, int rs2, bit taken, int k);
    emit(enc_i(k, 0, 0, 20, op_i));
    emit(enc_b(8, rs2, rs1, f3));
    emit(enc_i(256, 20, 0, 20, op_i));
    store_result(20, taken ? k : k + 256);
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'd100;
    b = -32'sd7;
    pc = 0;
    st_off = 0;
    emit(enc_i(data_base, 0, 0, 1, op_i));
    emit(enc_i(100, 0, 0, 2, op_i));
    emit(enc_i(-7, 0, 0, 3, op_i));
    emit(enc_r(0, 3, 2, 0, 4));
    store_result(4, a + b);
    emit(enc_r(32, 2, 3, 0, 5));
    store_result(5, b - a);
    emit(enc_r(0, 3, 2, 1, 6));
    store_result(6, a << 25);
    emit(enc_i(12'h403, 3, 5, 7, op_i));
    store_result(7, $signed(b) >>> 3);
    emit(enc_r(0, 2, 3, 5, 8));
    store_result(8, b >> 4);
    emit(enc_r(32, 2, 3, 5, 9));
    store_result(9, $signed(b) >>> 4);
    emit(enc_r(0, 2, 3, 2, 10));
    store_result(10, 32'd1);
    emit(enc_r(0, 2, 3, 3, 11));
    store_result(11, 32'd0);
    emit(enc_i(-1, 3, 2, 12, op_i));
    store_result(12, 32'd1);
    emit(enc_i(-1, 2, 3, 13, op_i));
    store_result(13, 32'd1);
    emit(enc_r(0, 3, 2, 4, 14));
    store_result(14, a ^ b);
    emit(enc_r(0, 3, 2, 6, 15));
    store_result(15, a | b);
    emit(enc_r(0, 3, 2, 7, 16));
    store_result(16, a & b);
    emit(enc_i(12'h0f0, 3, 4, 17, op_i));
    store_result(17, b ^ 32'h0f0);
    emit({20'h12345, 5'd19, 7'h37});
    store_result(19, 32'h12345000);
    emit({20'habcde, 5'd19, 7'h17});
    store_result(19, (pc - 4) + 32'habcde000);
    // x0 keeps zero after a write.
    emit(enc_i(5, 0, 0, 0, op_i));
    store_result(0, 32'd0);

    branch_case(0, 2, 2, 1, 1);
    branch_case(0, 2, 3, 0, 2);
    branch_case(1, 2, 3, 1, 3);
    branch_case(1, 2, 2, 0, 4);
    branch_case(4, 3, 2, 1, 5);
    branch_case(4, 2, 3, 0, 6);
    branch_case(5, 2, 3, 1, 7);
    branch_case(5, 3, 2, 0, 8);
    branch_case(6, 2, 3, 1, 9);
    branch_case(6, 3, 2, 0, 10);
    branch_case(7, 3, 2, 1, 11);
    branch_case(7, 2, 3, 0, 12);

    // JAL over a store that must never appear.
    emit(enc_j(8, 21));
    emit(enc_s(12'h1fc, 3, 1, 2));
    store_result(21, pc - 4);
    emit({20'h0, 5'd22, 7'h17});
    emit(enc_i(13, 22, 0, 23, 7'h67));
    emit(enc_s(12'h1fc, 3, 1, 2));
    store_result(23, pc - 4);

    emit(enc_i(12'h080, 0, 0, 24, op_i));
    emit({20'h00008, 5'd25, 7'h37});
    for (int off = 0; off < 4; off++) begin
      emit(enc_s(12'h1c0 + off, 24, 1, 0));
      expect_store(32'h3c0, 32'h80 << (8 * off), 4'b0001 << off);
    end
    emit(enc_s(12'h1c4, 25, 1, 1));
    expect_store(32'h3c4, 32'h0000_8000, 4'b0011);
    emit(enc_s(12'h1c6, 25, 1, 1));
    expect_store(32'h3c4, 32'h8000_0000, 4'b1100);
    emit(enc_i(12'h1c1, 1, 0, 26, op_ld));
    store_result(26, 32'hffff_ff80);
    emit(enc_i(12'h1c2, 1, 4, 26, op_ld));
    store_result(26, 32'h0000_0080);
    emit(enc_i(12'h1c6, 1, 1, 26, op_ld));
    store_result(26, 32'hffff_8000);
    emit(enc_i(12'h1c4, 1, 5, 26, op_ld));
    store_result(26, 32'h0000_8000);
    emit(enc_i(12'h1c4, 1, 2, 26, op_ld));
    store_result(26, 32'h8000_8000);

    // Count to three, then record the exit.
    emit(enc_i(0, 0, 0, 27, op_i));
    emit(enc_i(3, 0, 0, 28, op_i));
    emit(enc_i(1, 27, 0, 27, op_i));
    emit(enc_b(-4, 28, 27, 1));
    store_result(27, 32'd3);
    emit(enc_j(0, 0));
  endtask

  // Bus memory model with 0 to 3 random wait cycles per access.
  always @(posedge clk) begin
    if (!arst_n) begin
      istr_waitrequest <= 1'b1;
      data_waitrequest <= 1'b1;
      iwait <= 0;
      dwait <= 0;
    end else begin
      if (istr_read) begin
        if (!istr_waitrequest) begin
          istr_waitrequest <= 1'b1;
          iwait <= $urandom % 4;
        end else if (iwait == 0) begin
          istr_waitrequest <= 1'b0;
          istr_readdata <= mem[istr_address[9:2]];
        end else begin
          iwait <= iwait - 1;
        end
      end
      if (data_read || data_write) begin
        if (!data_waitrequest) begin
          data_waitrequest <= 1'b1;
          dwait <= $urandom % 4;
        end else if (dwait == 0) begin
          data_waitrequest <= 1'b0;
          data_readdata <= mem[data_address[9:2]];
        end else begin
          dwait <= dwait - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && data_write && !data_waitrequest) begin
      mask = {{8{data_byteenable[3]}}, {8{data_byteenable[2]}},
              {8{data_byteenable[1]}}, {8{data_byteenable[0]}}};
      mem[data_address[9:2]] = (mem[data_address[9:2]] & ~mask) | (data_writedata & mask);
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Unexpected store to address %h", data_address);
      end else begin
        head = exp_q.pop_front();
        assert (data_address == head.addr && data_byteenable == head.be &&
                ((data_writedata ^ head.data) & mask) == '0)
        else begin
          store_errors++;
          $display(
            "Fail data_address %h exp %h, data_writedata %h exp %h, data_byteenable %h exp %h",
            data_address, head.addr, data_writedata, head.data, data_byteenable, head.be);
        end
      end
    end
  end

  // Fetch order and first fetch address.
  always @(posedge clk) begin
    if (arst_n && istr_read && !seen_fetch) begin
      seen_fetch = 1'b1;
      assert (istr_address == reset_pc)
      else begin
        bus_errors++;
        $display("Fail istr_address: %h exp %h", istr_address, reset_pc);
      end
    end
    if (arst_n && istr_read && !istr_waitrequest) begin
      if (have_prev) begin
        prev_op = mem[prev_fetch[9:2]][6:0];
        if (prev_op != 7'h6f && prev_op != 7'h67 && prev_op != 7'h63) begin
          assert (istr_address == prev_fetch + 4)
          else begin
            bus_errors++;
            $display("Fail istr_address: %h exp %h", istr_address, prev_fetch + 4);
          end
        end
      end
      prev_fetch = istr_address;
      have_prev = 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    istr_read && istr_waitrequest |=> istr_read && $stable(istr_address))
  else begin
    bus_errors++;
    $display("Instruction read changed while waitrequest was high");
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    (data_read || data_write) && data_waitrequest |=>
      $stable({data_read, data_write, data_address, data_writedata, data_byteenable}))
  else begin
    bus_errors++;
    $display("Data access changed while waitrequest was high");
  end

  assert property (@(posedge clk) !(istr_read && (data_read || data_write)))
  else begin
    bus_errors++;
    $display("Instruction and data accesses overlapped");
  end

  assert property (@(posedge clk) !arst_n |-> !istr_read && !data_read && !data_write)
  else begin
    bus_errors++;
    $display("Bus strobe high during reset");
  end

  initial begin
    clk = 1'b0;
    arst_n = 1'b1;
    istr_readdata = '0;
    istr_waitrequest = 1'b1;
    data_readdata = '0;
    data_waitrequest = 1'b1;
    cycles = 0;
    have_prev = 1'b0;
    seen_fetch = 1'b0;
    store_errors = 0;
    bus_errors = 0;
    other_errors = 0;
    void'($urandom(32'h6fb));
    for (int i = 0; i < 256; i++) begin
      mem[i] = ~(i * 4) ^ 32'h5a5a_0000;
    end
    build_program();
    // Worst case per instruction is two accesses with waits plus four states.
    limit = (pc / 4) * 14 + 200;
    #1 arst_n = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    while (exp_q.size() != 0 && cycles < limit) @(posedge clk);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Timeout after %0d cycles with %0d stores still expected", cycles, exp_q.size());
    end else begin
      repeat (20) @(posedge clk);
    end
    $display("Errors: store %0d, bus %0d, other %0d", store_errors, bus_errors, other_errors);
    if (store_errors + bus_errors + other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/core_isa_pkg.sv
design/core_bus_pkg.sv
design/core_exec_if.sv
design/core_ctrl.sv
design/core_ifu.sv
design/core_decoder.sv
design/core_regfile.sv
design/core_alu.sv
design/core_lsu.sv
design/core_top.sv
tb/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - design/core_isa_pkg.sv
  - design/core_bus_pkg.sv
  - design/core_exec_if.sv
  - design/core_ctrl.sv
  - design/core_ifu.sv
  - design/core_decoder.sv
  - design/core_regfile.sv
  - design/core_alu.sv
  - design/core_lsu.sv
  - design/core_top.sv
  - target: test
    files:
      - tb/core_tb.sv
